// File: fetch.f
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/if1_if2.sv
logic/predecode.sv
logic/if2_id1.sv
logic/inst_buffer.sv
logic/fetch_top.sv
verification/fetch_tb.sv

// File: logic/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////
    // Front end constants
    ////////////////////////////////////////

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    localparam int IBUF_DEPTH = 8;

    // Branch type sits above the 32-bit predicted PC
    localparam int BRINFO_W = 34;

    ////////////////////////////////////////
    // Major opcodes, inst[31:26]
    ////////////////////////////////////////

    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    localparam logic [5:0] OP_BEQ  = 6'b010110;
    localparam logic [5:0] OP_BNE  = 6'b010111;
    localparam logic [5:0] OP_BLT  = 6'b011000;
    localparam logic [5:0] OP_BGE  = 6'b011001;
    localparam logic [5:0] OP_BLTU = 6'b011010;
    localparam logic [5:0] OP_BGEU = 6'b011011;

    typedef enum logic [1:0] {
        BR_NONE     = 2'd0,
        BR_COND     = 2'd1,
        BR_DIRECT   = 2'd2,
        BR_INDIRECT = 2'd3
    } brtype_t;

    typedef enum logic [7:0] {
        ECODE_NONE = 8'h00,
        ECODE_ADEF = 8'h08
    } ecode_t;

endpackage

// File: logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                           clk,
    input  logic                           rstn,
    output logic [31:0]                    o_imem_addr,
    input  logic [63:0]                    i_imem_data,
    input  logic                           i_flush_br,
    input  logic [31:0]                    i_flush_target,
    input  logic                           i_issue_ready,
    output logic [1:0]                     o_issue_valid,
    output logic [31:0]                    o_issue_pc1,
    output logic [31:0]                    o_issue_ir1,
    output logic [fetch_pkg::BRINFO_W-1:0] o_issue_brinfo1,
    output fetch_pkg::ecode_t              o_issue_ecode1,
    output logic [31:0]                    o_issue_pc2,
    output logic [31:0]                    o_issue_ir2,
    output logic [fetch_pkg::BRINFO_W-1:0] o_issue_brinfo2,
    output fetch_pkg::ecode_t              o_issue_ecode2
);

    import fetch_pkg::*;

    logic [31:0]         fetch_pc;
    logic [31:0]         mem_pc;
    logic                stall_full;
    logic                redirect;
    logic [31:0]         redirect_target;

    logic [31:0]         if2_pc;
    logic [31:0]         if2_pc2;
    logic [1:0]          if2_valid;
    ecode_t              if2_ecode1;
    ecode_t              if2_ecode2;

    logic [31:0]         pd_ir1;
    logic [31:0]         pd_ir2;
    logic [BRINFO_W-1:0] pd_brinfo1;
    logic [BRINFO_W-1:0] pd_brinfo2;
    logic [1:0]          pd_valid;

    logic [31:0]         id1_pc1;
    logic [31:0]         id1_pc2;
    logic [31:0]         id1_ir1;
    logic [31:0]         id1_ir2;
    logic [BRINFO_W-1:0] id1_brinfo1;
    logic [BRINFO_W-1:0] id1_brinfo2;
    ecode_t              id1_ecode1;
    ecode_t              id1_ecode2;
    logic [1:0]          id1_valid;

    // While stalled, refetch the IF2 line so its data is still there at release
    assign mem_pc      = stall_full ? if2_pc : fetch_pc;
    assign o_imem_addr = {mem_pc[31:3], 1'b0, mem_pc[1:0]};

    // Slot 2 is always an aligned fetch
    assign if2_pc2    = if2_pc + 32'd4;
    assign if2_ecode2 = ECODE_NONE;

    ////////////////////////////////////////
    // Fetch stages
    ////////////////////////////////////////

    pc_gen u_pc_gen (
        .clk               (clk),
        .rstn              (rstn),
        .i_flush           (i_flush_br),
        .i_flush_target    (i_flush_target),
        .i_redirect        (redirect),
        .i_redirect_target (redirect_target),
        .i_stall           (stall_full),
        .o_pc              (fetch_pc)
    );

    if1_if2 u_if1_if2 (
        .clk        (clk),
        .rstn       (rstn),
        .i_pc       (fetch_pc),
        .i_flush    (i_flush_br),
        .i_kill     (redirect),
        .i_stall    (stall_full),
        .o_pc       (if2_pc),
        .o_is_valid (if2_valid),
        .o_ecode1   (if2_ecode1)
    );

    predecode u_predecode (
        .i_pc              (if2_pc),
        .i_is_valid        (if2_valid),
        .i_imem_data       (i_imem_data),
        .o_ir1             (pd_ir1),
        .o_ir2             (pd_ir2),
        .o_brinfo1         (pd_brinfo1),
        .o_brinfo2         (pd_brinfo2),
        .o_is_valid        (pd_valid),
        .o_redirect        (redirect),
        .o_redirect_target (redirect_target)
    );

    if2_id1 u_if2_id1 (
        .clk          (clk),
        .rstn         (rstn),
        .i_pc1        (if2_pc),
        .i_ir1        (pd_ir1),
        .i_brinfo1    (pd_brinfo1),
        .i_ecode1     (if2_ecode1),
        .i_pc2        (if2_pc2),
        .i_ir2        (pd_ir2),
        .i_brinfo2    (pd_brinfo2),
        .i_ecode2     (if2_ecode2),
        .i_is_valid   (pd_valid),
        .i_flush_br   (i_flush_br),
        .i_stall_full (stall_full),
        .o_pc1        (id1_pc1),
        .o_ir1        (id1_ir1),
        .o_brinfo1    (id1_brinfo1),
        .o_ecode1     (id1_ecode1),
        .o_pc2        (id1_pc2),
        .o_ir2        (id1_ir2),
        .o_brinfo2    (id1_brinfo2),
        .o_ecode2     (id1_ecode2),
        .o_is_valid   (id1_valid)
    );

    ////////////////////////////////////////
    // Instruction buffer and issue
    ////////////////////////////////////////

    inst_buffer u_inst_buffer (
        .clk             (clk),
        .rstn            (rstn),
        .i_flush         (i_flush_br),
        .i_push_valid    (id1_valid),
        .i_pc1           (id1_pc1),
        .i_ir1           (id1_ir1),
        .i_brinfo1       (id1_brinfo1),
        .i_ecode1        (id1_ecode1),
        .i_pc2           (id1_pc2),
        .i_ir2           (id1_ir2),
        .i_brinfo2       (id1_brinfo2),
        .i_ecode2        (id1_ecode2),
        .i_issue_ready   (i_issue_ready),
        .o_issue_valid   (o_issue_valid),
        .o_issue_pc1     (o_issue_pc1),
        .o_issue_ir1     (o_issue_ir1),
        .o_issue_brinfo1 (o_issue_brinfo1),
        .o_issue_ecode1  (o_issue_ecode1),
        .o_issue_pc2     (o_issue_pc2),
        .o_issue_ir2     (o_issue_ir2),
        .o_issue_brinfo2 (o_issue_brinfo2),
        .o_issue_ecode2  (o_issue_ecode2),
        .o_stall_full    (stall_full)
    );

endmodule

// File: logic/if1_if2.sv
`timescale 1ns/1ps

module if1_if2 (
    input  logic               clk,
    input  logic               rstn,
    input  logic [31:0]        i_pc,
    input  logic               i_flush,
    input  logic               i_kill,
    input  logic               i_stall,
    output logic [31:0]        o_pc,
    output logic [1:0]         o_is_valid,
    output fetch_pkg::ecode_t  o_ecode1
);

    import fetch_pkg::*;

    logic       misaligned;
    logic [1:0] slot_valid;
    logic [1:0] valid_q;

    assign misaligned = |i_pc[1:0];
    // Slot 2 only exists for an aligned even-word PC
    assign slot_valid = (misaligned || i_pc[2]) ? 2'b01 : 2'b11;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 2'b00;
        end
        else if (i_flush) begin
            valid_q <= 2'b00;
        end
        else if (i_stall) begin
            valid_q <= valid_q;
        end
        else if (i_kill) begin
            valid_q <= 2'b00;
        end
        else begin
            valid_q <= slot_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_pc     <= i_pc;
            o_ecode1 <= misaligned ? ECODE_ADEF : ECODE_NONE;
        end
    end

    assign o_is_valid = valid_q;

endmodule

// File: logic/if2_id1.sv
`timescale 1ns/1ps

module if2_id1 (
    input  logic                           clk,
    input  logic                           rstn,

    input  logic [31:0]                    i_pc1,
    input  logic [31:0]                    i_ir1,
    input  logic [fetch_pkg::BRINFO_W-1:0] i_brinfo1,
    input  fetch_pkg::ecode_t              i_ecode1,

    input  logic [31:0]                    i_pc2,
    input  logic [31:0]                    i_ir2,
    input  logic [fetch_pkg::BRINFO_W-1:0] i_brinfo2,
    input  fetch_pkg::ecode_t              i_ecode2,

    input  logic [1:0]                     i_is_valid,
    input  logic                           i_flush_br,
    input  logic                           i_stall_full,

    output logic [31:0]                    o_pc1,
    output logic [31:0]                    o_ir1,
    output logic [fetch_pkg::BRINFO_W-1:0] o_brinfo1,
    output fetch_pkg::ecode_t              o_ecode1,

    output logic [31:0]                    o_pc2,
    output logic [31:0]                    o_ir2,
    output logic [fetch_pkg::BRINFO_W-1:0] o_brinfo2,
    output fetch_pkg::ecode_t              o_ecode2,

    output logic [1:0]                     o_is_valid
);

    logic [1:0] valid_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 2'b00;
        end
        else if (i_flush_br) begin
            valid_q <= 2'b00;
        end
        else if (i_stall_full) begin
            valid_q <= valid_q;
        end
        else begin
            valid_q <= i_is_valid;
        end
    end

    // Held pair is hidden until the buffer has room
    assign o_is_valid = valid_q & {2{~i_stall_full}};

    ////////////////////////////////////////
    // Instruction payload
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_stall_full) begin
            o_pc1     <= i_pc1;
            o_ir1     <= i_ir1;
            o_brinfo1 <= i_brinfo1;
            o_ecode1  <= i_ecode1;
            o_pc2     <= i_pc2;
            o_ir2     <= i_ir2;
            o_brinfo2 <= i_brinfo2;
            o_ecode2  <= i_ecode2;
        end
    end

endmodule

// File: logic/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           i_flush,
    input  logic [1:0]                     i_push_valid,
    input  logic [31:0]                    i_pc1,
    input  logic [31:0]                    i_ir1,
    input  logic [fetch_pkg::BRINFO_W-1:0] i_brinfo1,
    input  fetch_pkg::ecode_t              i_ecode1,
    input  logic [31:0]                    i_pc2,
    input  logic [31:0]                    i_ir2,
    input  logic [fetch_pkg::BRINFO_W-1:0] i_brinfo2,
    input  fetch_pkg::ecode_t              i_ecode2,
    input  logic                           i_issue_ready,
    output logic [1:0]                     o_issue_valid,
    output logic [31:0]                    o_issue_pc1,
    output logic [31:0]                    o_issue_ir1,
    output logic [fetch_pkg::BRINFO_W-1:0] o_issue_brinfo1,
    output fetch_pkg::ecode_t              o_issue_ecode1,
    output logic [31:0]                    o_issue_pc2,
    output logic [31:0]                    o_issue_ir2,
    output logic [fetch_pkg::BRINFO_W-1:0] o_issue_brinfo2,
    output fetch_pkg::ecode_t              o_issue_ecode2,
    output logic                           o_stall_full
);

    import fetch_pkg::*;

    localparam int PTR_W = $clog2(IBUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [31:0]         pc_mem     [IBUF_DEPTH];
    logic [31:0]         ir_mem     [IBUF_DEPTH];
    logic [BRINFO_W-1:0] brinfo_mem [IBUF_DEPTH];
    ecode_t              ecode_mem  [IBUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr2;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr2;
    logic [CNT_W-1:0] count;
    logic [1:0]       push_n;
    logic [1:0]       pop_n;
    logic [1:0]       pop_valid;

    assign push_n    = {1'b0, i_push_valid[0]} + {1'b0, i_push_valid[1]};
    assign pop_valid = o_issue_valid & {2{i_issue_ready}};
    assign pop_n     = {1'b0, pop_valid[0]} + {1'b0, pop_valid[1]};
    // Slot 2 lands right behind slot 1 when both arrive
    assign wr_ptr2   = wr_ptr + PTR_W'(i_push_valid[0]);
    assign rd_ptr2   = rd_ptr + PTR_W'(1);

    always_ff @(posedge clk) begin
        if (!rstn || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_n);
            wr_ptr <= wr_ptr + PTR_W'(push_n);
            count  <= count + CNT_W'(push_n) - CNT_W'(pop_n);
        end
    end

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_push_valid[0]) begin
            pc_mem[wr_ptr]     <= i_pc1;
            ir_mem[wr_ptr]     <= i_ir1;
            brinfo_mem[wr_ptr] <= i_brinfo1;
            ecode_mem[wr_ptr]  <= i_ecode1;
        end
        if (i_push_valid[1]) begin
            pc_mem[wr_ptr2]     <= i_pc2;
            ir_mem[wr_ptr2]     <= i_ir2;
            brinfo_mem[wr_ptr2] <= i_brinfo2;
            ecode_mem[wr_ptr2]  <= i_ecode2;
        end
    end

    // Two oldest entries, slot 2 only with slot 1
    always_comb begin
        if (i_flush || count == '0)
            o_issue_valid = 2'b00;
        else if (count == CNT_W'(1))
            o_issue_valid = 2'b01;
        else
            o_issue_valid = 2'b11;
    end

    assign o_issue_pc1     = pc_mem[rd_ptr];
    assign o_issue_ir1     = ir_mem[rd_ptr];
    assign o_issue_brinfo1 = brinfo_mem[rd_ptr];
    assign o_issue_ecode1  = ecode_mem[rd_ptr];
    assign o_issue_pc2     = pc_mem[rd_ptr2];
    assign o_issue_ir2     = ir_mem[rd_ptr2];
    assign o_issue_brinfo2 = brinfo_mem[rd_ptr2];
    assign o_issue_ecode2  = ecode_mem[rd_ptr2];

    // Fewer than two free entries
    assign o_stall_full = count > CNT_W'(IBUF_DEPTH - 2);

endmodule

// File: logic/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_flush,
    input  logic [31:0] i_flush_target,
    input  logic        i_redirect,
    input  logic [31:0] i_redirect_target,
    input  logic        i_stall,
    output logic [31:0] o_pc
);

    import fetch_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_seq;

    // Odd word address only fetches one slot, so step by one word
    assign pc_seq = pc_q[2] ? pc_q + 32'd4 : pc_q + 32'd8;

    ////////////////////////////////////////
    // Fetch PC register
    ////////////////////////////////////////

    // Backend flush wins over the static prediction
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q <= RESET_PC;
        end
        else if (i_flush) begin
            pc_q <= i_flush_target;
        end
        else if (i_redirect) begin
            pc_q <= i_redirect_target;
        end
        else if (i_stall) begin
            pc_q <= pc_q;
        end
        else begin
            pc_q <= pc_seq;
        end
    end

    assign o_pc = pc_q;

endmodule

// File: logic/predecode.sv
`timescale 1ns/1ps

module predecode (
    input  logic [31:0]                   i_pc,
    input  logic [1:0]                    i_is_valid,
    input  logic [63:0]                   i_imem_data,
    output logic [31:0]                   o_ir1,
    output logic [31:0]                   o_ir2,
    output logic [fetch_pkg::BRINFO_W-1:0] o_brinfo1,
    output logic [fetch_pkg::BRINFO_W-1:0] o_brinfo2,
    output logic [1:0]                    o_is_valid,
    output logic                          o_redirect,
    output logic [31:0]                   o_redirect_target
);

    import fetch_pkg::*;

    logic [31:0] pc2;
    brtype_t     bt1;
    brtype_t     bt2;
    logic        taken1;
    logic        taken2;
    logic [31:0] pred1;
    logic [31:0] pred2;

    function automatic brtype_t classify(input logic [31:0] ir);
        case (ir[31:26])
            OP_B, OP_BL: classify = BR_DIRECT;
            OP_JIRL:     classify = BR_INDIRECT;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: classify = BR_COND;
            default:     classify = BR_NONE;
        endcase
    endfunction

    // Backward conditional branches are guessed taken
    function automatic logic is_taken(input logic [31:0] ir, input brtype_t bt);
        is_taken = (bt == BR_DIRECT) || (bt == BR_COND && ir[25]);
    endfunction

    function automatic logic [31:0] predict(input logic [31:0] pc, input logic [31:0] ir,
                                            input brtype_t bt);
        logic [31:0] offs26;
        logic [31:0] offs16;
        offs26 = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};
        offs16 = {{14{ir[25]}}, ir[25:10], 2'b00};
        if (bt == BR_DIRECT)
            predict = pc + offs26;
        else if (bt == BR_COND && ir[25])
            predict = pc + offs16;
        else
            predict = pc + 32'd4;
    endfunction

    // Low word of the line is the even address
    assign o_ir1 = i_pc[2] ? i_imem_data[63:32] : i_imem_data[31:0];
    assign o_ir2 = i_imem_data[63:32];
    assign pc2   = i_pc + 32'd4;

    assign bt1    = classify(o_ir1);
    assign bt2    = classify(o_ir2);
    assign pred1  = predict(i_pc, o_ir1, bt1);
    assign pred2  = predict(pc2, o_ir2, bt2);
    assign taken1 = i_is_valid[0] && is_taken(o_ir1, bt1);
    assign taken2 = i_is_valid[1] && is_taken(o_ir2, bt2);

    assign o_brinfo1 = {bt1, pred1};
    assign o_brinfo2 = {bt2, pred2};

    // Taken slot 1 drops slot 2
    assign o_is_valid        = {i_is_valid[1] & ~taken1, i_is_valid[0]};
    assign o_redirect        = taken1 | taken2;
    assign o_redirect_target = taken1 ? pred1 : pred2;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f fetch.f --top-module fetch_tb -o fetch_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi
exit 0

// File: verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    logic                clk;
    logic                rstn;
    logic [31:0]         o_imem_addr;
    logic [63:0]         i_imem_data = 64'd0;
    logic                i_flush_br;
    logic [31:0]         i_flush_target;
    logic                i_issue_ready;
    logic [1:0]          o_issue_valid;
    logic [31:0]         o_issue_pc1;
    logic [31:0]         o_issue_ir1;
    logic [BRINFO_W-1:0] o_issue_brinfo1;
    ecode_t              o_issue_ecode1;
    logic [31:0]         o_issue_pc2;
    logic [31:0]         o_issue_ir2;
    logic [BRINFO_W-1:0] o_issue_brinfo2;
    ecode_t              o_issue_ecode2;

    logic [31:0] prog [512];
    logic [31:0] lfsr = 32'h2cee_5f83;
    logic [31:0] addr_q;
    logic        rst_q = 1'b0;
    logic [31:0] exp_pc;
    int          issued;
    string       test_name;

    int straight_len = 200;
    int pressure_len = 300;
    int flush_rounds = 12;

    fetch_top uut (
        .clk             (clk),
        .rstn            (rstn),
        .o_imem_addr     (o_imem_addr),
        .i_imem_data     (i_imem_data),
        .i_flush_br      (i_flush_br),
        .i_flush_target  (i_flush_target),
        .i_issue_ready   (i_issue_ready),
        .o_issue_valid   (o_issue_valid),
        .o_issue_pc1     (o_issue_pc1),
        .o_issue_ir1     (o_issue_ir1),
        .o_issue_brinfo1 (o_issue_brinfo1),
        .o_issue_ecode1  (o_issue_ecode1),
        .o_issue_pc2     (o_issue_pc2),
        .o_issue_ir2     (o_issue_ir2),
        .o_issue_brinfo2 (o_issue_brinfo2),
        .o_issue_ecode2  (o_issue_ecode2)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model of the fetch rules
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] pc);
        return prog[pc[10:2]];
    endfunction

    function automatic brtype_t branch_type(input logic [31:0] ir);
        logic [5:0] op;
        op = ir[31:26];
        if (op == OP_B || op == OP_BL)
            return BR_DIRECT;
        if (op == OP_JIRL)
            return BR_INDIRECT;
        if (op >= OP_BEQ && op <= OP_BGEU)
            return BR_COND;
        return BR_NONE;
    endfunction

    function automatic logic predicted_taken(input logic [31:0] ir);
        brtype_t bt;
        bt = branch_type(ir);
        return bt == BR_DIRECT || (bt == BR_COND && ir[25]);
    endfunction

    function automatic logic [31:0] predicted_pc(input logic [31:0] pc, input logic [31:0] ir);
        logic [25:0] off26;
        off26 = {ir[9:0], ir[25:10]};
        if (branch_type(ir) == BR_DIRECT)
            return pc + (32'($signed(off26)) << 2);
        if (branch_type(ir) == BR_COND && ir[25])
            return pc + (32'($signed(ir[25:10])) << 2);
        return pc + 32'd4;
    endfunction

    function automatic logic [31:0] next_pc(input logic [31:0] pc);
        logic [31:0] ir;
        ir = mem_word(pc);
        if (predicted_taken(ir))
            return predicted_pc(pc, ir);
        // Misaligned even-word fetch has no slot 2, so the pair step is eight
        if (pc[1:0] != 2'b00 && !pc[2])
            return pc + 32'd8;
        return pc + 32'd4;
    endfunction

    function automatic logic [BRINFO_W-1:0] expected_brinfo(input logic [31:0] pc);
        logic [31:0] ir;
        ir = mem_word(pc);
        return {branch_type(ir), predicted_pc(pc, ir)};
    endfunction

    function automatic ecode_t expected_ecode(input logic [31:0] pc);
        if (pc[1:0] != 2'b00)
            return ECODE_ADEF;
        return ECODE_NONE;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] r);
        r = 32'd0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
    endtask

    task automatic fill_program();
        logic [31:0] kind;
        logic [31:0] word;
        logic [31:0] r;
        logic [25:0] off26;
        logic [15:0] off16;
        for (logic [9:0] a = 10'd0; a < 10'd512; a++) begin
            draw_bits(4, kind);
            draw_bits(32, word);
            draw_bits(7, r);
            // Opcode bit 4 low keeps plain words out of the branch group
            word[30] = 1'b0;
            off26    = {{19{r[6]}}, r[6:0]} | 26'd1;
            off16    = {12'd0, r[3:0]} + 16'd1;
            case (kind[3:0])
                4'd8:         word = {OP_B, off26[15:0], off26[25:16]};
                4'd9:         word = {OP_BL, off26[15:0], off26[25:16]};
                4'd10:        word = {OP_JIRL, word[25:0]};
                4'd11, 4'd12: word = {OP_BEQ + 6'(r[6:4] % 3'd6), off16, word[9:0]};
                4'd13:        word = {OP_BEQ + 6'(r[6:4] % 3'd6), -off16, word[9:0]};
                default:      ;
            endcase
            prog[a[8:0]] = word;
        end
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic value_fail(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        stop_run($sformatf("Fail %s: %s expected %h actual %h",
                           test_name, what, expected, actual));
    endtask

    ////////////////////////////////////////
    // Memory model and issue tracking
    ////////////////////////////////////////

    always @(posedge clk) addr_q <= o_imem_addr;

    // Line lands on the falling edge, ahead of the IF2 capture
    always @(negedge clk) begin
        i_imem_data <= {prog[{addr_q[10:3], 1'b1}], prog[{addr_q[10:3], 1'b0}]};
    end

    always @(posedge clk) rst_q <= rstn;

    always @(posedge clk) begin : track_issue
        logic [31:0] nxt;
        int          n;
        nxt = exp_pc;
        n   = 0;
        if (i_issue_ready && o_issue_valid[0]) begin
            nxt = next_pc(o_issue_pc1);
            n   = 1;
        end
        if (i_issue_ready && o_issue_valid[1]) begin
            nxt = next_pc(o_issue_pc2);
            n   = 2;
        end
        if (!rstn) begin
            exp_pc <= RESET_PC;
            issued <= 0;
        end
        else if (i_flush_br) begin
            exp_pc <= i_flush_target;
        end
        else begin
            exp_pc <= nxt;
            issued <= issued + n;
        end
    end

    ////////////////////////////////////////
    // Checks on the issue port
    ////////////////////////////////////////

    reset_quiet: assert property (@(posedge clk) (!rstn || !rst_q) |-> o_issue_valid == 2'b00)
        else value_fail("issue valid near reset", 64'd0, 64'($sampled(o_issue_valid)));

    // Memory lines are fetched on a doubleword boundary
    imem_line: assert property (@(posedge clk) o_imem_addr[2] == 1'b0)
        else value_fail("imem addr bit 2", 64'd0, 64'($sampled(o_imem_addr[2])));

    slot_order: assert property (@(posedge clk) o_issue_valid != 2'b10)
        else stop_run($sformatf("Slot 2 issued without slot 1 in test %s", test_name));

    pc1_order: assert property (@(posedge clk) o_issue_valid[0] |-> o_issue_pc1 == exp_pc)
        else value_fail("slot 1 pc", 64'($sampled(exp_pc)), 64'($sampled(o_issue_pc1)));

    ir1_word: assert property (@(posedge clk)
            o_issue_valid[0] |-> o_issue_ir1 == mem_word(o_issue_pc1))
        else value_fail("slot 1 ir", 64'(mem_word($sampled(o_issue_pc1))),
                        64'($sampled(o_issue_ir1)));

    brinfo1_rule: assert property (@(posedge clk)
            o_issue_valid[0] |-> o_issue_brinfo1 == expected_brinfo(o_issue_pc1))
        else value_fail("slot 1 brinfo",
                        64'(expected_brinfo($sampled(o_issue_pc1))),
                        64'($sampled(o_issue_brinfo1)));

    ecode1_rule: assert property (@(posedge clk)
            o_issue_valid[0] |-> o_issue_ecode1 == expected_ecode(o_issue_pc1))
        else value_fail("slot 1 ecode", 64'(expected_ecode($sampled(o_issue_pc1))),
                        64'($sampled(o_issue_ecode1)));

    pc2_order: assert property (@(posedge clk)
            o_issue_valid[1] |-> o_issue_pc2 == next_pc(o_issue_pc1))
        else value_fail("slot 2 pc",
                        64'(next_pc($sampled(o_issue_pc1))),
                        64'($sampled(o_issue_pc2)));

    ir2_word: assert property (@(posedge clk)
            o_issue_valid[1] |-> o_issue_ir2 == mem_word(o_issue_pc2))
        else value_fail("slot 2 ir", 64'(mem_word($sampled(o_issue_pc2))),
                        64'($sampled(o_issue_ir2)));

    brinfo2_rule: assert property (@(posedge clk)
            o_issue_valid[1] |-> o_issue_brinfo2 == expected_brinfo(o_issue_pc2))
        else value_fail("slot 2 brinfo",
                        64'(expected_brinfo($sampled(o_issue_pc2))),
                        64'($sampled(o_issue_brinfo2)));

    ecode2_rule: assert property (@(posedge clk)
            o_issue_valid[1] |-> o_issue_ecode2 == expected_ecode(o_issue_pc2))
        else value_fail("slot 2 ecode", 64'(expected_ecode($sampled(o_issue_pc2))),
                        64'($sampled(o_issue_ecode2)));

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic wait_issued(input int count);
        int goal;
        goal = issued + count;
        while (issued < goal)
            @(negedge clk);
    endtask

    task automatic run_backpressure(input int count);
        int          goal;
        logic [31:0] r;
        goal = issued + count;
        while (issued < goal) begin
            draw_bits(5, r);
            i_issue_ready = 1'b0;
            repeat (r + 4) @(negedge clk);
            draw_bits(4, r);
            i_issue_ready = 1'b1;
            repeat (r + 1) @(negedge clk);
        end
    endtask

    task automatic run_flushes(input int rounds);
        logic [31:0] r;
        logic [31:0] target;
        for (int k = 0; k < rounds; k++) begin
            i_issue_ready = 1'b0;
            draw_bits(3, r);
            repeat (r + 2) @(negedge clk);
            draw_bits(10, r);
            target = RESET_PC + {21'd0, r[8:0], 2'b00};
            // Odd rounds land on a misaligned address
            if (k % 2 == 1)
                target[1:0] = {r[9], 1'b1};
            i_flush_target = target;
            i_flush_br     = 1'b1;
            @(negedge clk);
            i_flush_br = 1'b0;
            draw_bits(3, r);
            repeat (r + 1) @(negedge clk);
            i_issue_ready = 1'b1;
            wait_issued(24);
        end
    endtask

    initial begin : watchdog
        int limit;
        limit = 16 + 4 * straight_len + 12 * pressure_len + 120 * flush_rounds + 1000;
        repeat (limit) @(posedge clk);
        stop_run($sformatf("Timeout after %0d cycles with %0d instructions issued",
                           limit, issued));
    end

    initial begin
        rstn           = 1'b0;
        i_flush_br     = 1'b0;
        i_flush_target = 32'd0;
        i_issue_ready  = 1'b0;
        test_name      = "reset";
        fill_program();
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        test_name     = "straight";
        i_issue_ready = 1'b1;
        wait_issued(straight_len);

        test_name = "backpressure";
        run_backpressure(pressure_len);

        test_name = "flush";
        run_flushes(flush_rounds);

        $display("Issued %0d instructions", issued);
        $display("STATUS: PASS");
        $finish;
    end

endmodule
